/* vliwPkg.sv */
`default_nettype none

package vliwPkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// one bundle carries two slots
	localparam int BUNDLE_WIDTH = 60;
	localparam int SLOT_WIDTH = 30;
	localparam int OPCODE_WIDTH = 7;
	localparam int REG_ADDR_WIDTH = 5;
	// datapath, registers and operand field share this width
	localparam int DATA_WIDTH = 16;
	localparam int REG_COUNT = 32;
	// shifts only look at the low bits of the secondary
	localparam int SHIFT_WIDTH = 4;

	////////////////////////////////////////
	// slot field positions
	////////////////////////////////////////

	// slot a is the upper half of the bundle and slot b the lower half
	localparam int SLOT_BRANCH_BIT = 29;
	// format 0 is reg-reg and format 1 is reg-imm
	localparam int SLOT_FORMAT_BIT = 28;
	localparam int SLOT_OPCODE_LSB = 21;
	localparam int SLOT_REG_LSB = 16;
	// operand field starts at bit 0 and is DATA_WIDTH wide

	////////////////////////////////////////
	// opcodes
	////////////////////////////////////////

	localparam logic [OPCODE_WIDTH-1:0] OP_ADD = 7'd1;
	localparam logic [OPCODE_WIDTH-1:0] OP_SUB = 7'd2;
	localparam logic [OPCODE_WIDTH-1:0] OP_AND = 7'd3;
	localparam logic [OPCODE_WIDTH-1:0] OP_OR = 7'd4;
	localparam logic [OPCODE_WIDTH-1:0] OP_XOR = 7'd5;
	localparam logic [OPCODE_WIDTH-1:0] OP_SHL = 7'd6;
	localparam logic [OPCODE_WIDTH-1:0] OP_SHR = 7'd7;
	localparam logic [OPCODE_WIDTH-1:0] OP_MOV = 7'd8;

	// the defined opcodes form one contiguous range
	function automatic logic isValidOpcode(input logic [OPCODE_WIDTH-1:0] opcode);
		return (opcode >= OP_ADD) && (opcode <= OP_MOV);
	endfunction

	// operand field read either as an immediate or as a register index
	typedef union packed {
		logic [DATA_WIDTH-1:0] immView;
		struct packed {
			// upper bits carry nothing in reg-reg form
			logic [DATA_WIDTH-REG_ADDR_WIDTH-1:0] spare;
			logic [REG_ADDR_WIDTH-1:0] index;
		} regView;
	} slotOperand_u;

endpackage

`default_nettype wire

/* bundleDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bundleDecoder
(
	input wire clock_i,
	input wire reset_i,
	input wire bundleValid_i,
	input wire [vliwPkg::BUNDLE_WIDTH-1:0] bundle_i,

	// lane a
	output logic decValidA_o,
	output logic [vliwPkg::OPCODE_WIDTH-1:0] decOpcodeA_o,
	output logic [vliwPkg::REG_ADDR_WIDTH-1:0] decDestA_o,
	output logic decFormatA_o,
	output vliwPkg::slotOperand_u decOperandA_o,

	// lane b
	output logic decValidB_o,
	output logic [vliwPkg::OPCODE_WIDTH-1:0] decOpcodeB_o,
	output logic [vliwPkg::REG_ADDR_WIDTH-1:0] decDestB_o,
	output logic decFormatB_o,
	output vliwPkg::slotOperand_u decOperandB_o
);

	// raw slots split out of the bundle
	logic [vliwPkg::SLOT_WIDTH-1:0] slotA;
	logic [vliwPkg::SLOT_WIDTH-1:0] slotB;

	// branch slots are dropped here, as are unknown opcodes
	function automatic logic slotUsable(input logic [vliwPkg::SLOT_WIDTH-1:0] slot);
		logic [vliwPkg::OPCODE_WIDTH-1:0] opcode;
		opcode = slot[vliwPkg::SLOT_OPCODE_LSB +: vliwPkg::OPCODE_WIDTH];
		return !slot[vliwPkg::SLOT_BRANCH_BIT] && vliwPkg::isValidOpcode(opcode);
	endfunction

	// slot a in the upper half
	assign slotA = bundle_i[vliwPkg::BUNDLE_WIDTH-1 -: vliwPkg::SLOT_WIDTH];
	assign slotB = bundle_i[vliwPkg::SLOT_WIDTH-1:0];

	////////////////////////////////////////
	// qualification
	////////////////////////////////////////

	// the only place that decides whether a slot does anything
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			decValidA_o <= 1'b0;
			decValidB_o <= 1'b0;
		end
		else
		begin
			decValidA_o <= bundleValid_i && slotUsable(slotA);
			decValidB_o <= bundleValid_i && slotUsable(slotB);
		end
	end

	////////////////////////////////////////
	// field capture
	////////////////////////////////////////

	// fields only change on a strobe
	// downstream ignores them while the valid bit is low
	always_ff @(posedge clock_i)
	begin
		if (bundleValid_i)
		begin
			decOpcodeA_o <= slotA[vliwPkg::SLOT_OPCODE_LSB +: vliwPkg::OPCODE_WIDTH];
			decDestA_o <= slotA[vliwPkg::SLOT_REG_LSB +: vliwPkg::REG_ADDR_WIDTH];
			decFormatA_o <= slotA[vliwPkg::SLOT_FORMAT_BIT];
			decOperandA_o.immView <= slotA[vliwPkg::DATA_WIDTH-1:0];

			decOpcodeB_o <= slotB[vliwPkg::SLOT_OPCODE_LSB +: vliwPkg::OPCODE_WIDTH];
			decDestB_o <= slotB[vliwPkg::SLOT_REG_LSB +: vliwPkg::REG_ADDR_WIDTH];
			decFormatB_o <= slotB[vliwPkg::SLOT_FORMAT_BIT];
			decOperandB_o.immView <= slotB[vliwPkg::DATA_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile
(
	input wire clock_i,
	input wire reset_i,

	// decoded slots
	input wire decValidA_i,
	input wire [vliwPkg::OPCODE_WIDTH-1:0] decOpcodeA_i,
	input wire [vliwPkg::REG_ADDR_WIDTH-1:0] decDestA_i,
	input wire decFormatA_i,
	input wire vliwPkg::slotOperand_u decOperandA_i,
	input wire decValidB_i,
	input wire [vliwPkg::OPCODE_WIDTH-1:0] decOpcodeB_i,
	input wire [vliwPkg::REG_ADDR_WIDTH-1:0] decDestB_i,
	input wire decFormatB_i,
	input wire vliwPkg::slotOperand_u decOperandB_i,

	// writeback from the lanes
	input wire wbEnableA_i,
	input wire [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrA_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] wbDataA_i,
	input wire wbEnableB_i,
	input wire [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrB_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] wbDataB_i,

	// operands for execution
	output logic exValidA_o,
	output logic [vliwPkg::OPCODE_WIDTH-1:0] exOpcodeA_o,
	output logic [vliwPkg::REG_ADDR_WIDTH-1:0] exDestA_o,
	output logic [vliwPkg::DATA_WIDTH-1:0] exPrimaryA_o,
	output logic [vliwPkg::DATA_WIDTH-1:0] exSecondaryA_o,
	output logic exValidB_o,
	output logic [vliwPkg::OPCODE_WIDTH-1:0] exOpcodeB_o,
	output logic [vliwPkg::REG_ADDR_WIDTH-1:0] exDestB_o,
	output logic [vliwPkg::DATA_WIDTH-1:0] exPrimaryB_o,
	output logic [vliwPkg::DATA_WIDTH-1:0] exSecondaryB_o
);

	logic [vliwPkg::DATA_WIDTH-1:0] regArray [vliwPkg::REG_COUNT];

	// operand stage fields kept for the secondary select
	logic opFormatA;
	logic opFormatB;
	vliwPkg::slotOperand_u opOperandA;
	vliwPkg::slotOperand_u opOperandB;

	// array value unless a writeback lands at the next edge
	// lane b is checked last so it wins
	function automatic logic [vliwPkg::DATA_WIDTH-1:0] readBypass(
		input logic [vliwPkg::REG_ADDR_WIDTH-1:0] addr);
		logic [vliwPkg::DATA_WIDTH-1:0] value;
		value = regArray[addr];
		if (wbEnableA_i && (wbAddrA_i == addr))
			value = wbDataA_i;
		if (wbEnableB_i && (wbAddrB_i == addr))
			value = wbDataB_i;
		return value;
	endfunction

	////////////////////////////////////////
	// register array
	////////////////////////////////////////

	// lane b is written second and takes a shared address
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < vliwPkg::REG_COUNT; i++)
				regArray[i] <= '0;
		end
		else
		begin
			if (wbEnableA_i)
				regArray[wbAddrA_i] <= wbDataA_i;
			if (wbEnableB_i)
				regArray[wbAddrB_i] <= wbDataB_i;
		end
	end

	////////////////////////////////////////
	// operand stage
	////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			exValidA_o <= 1'b0;
			exValidB_o <= 1'b0;
		end
		else
		begin
			exValidA_o <= decValidA_i;
			exValidB_o <= decValidB_i;
		end
	end

	// slot fields travel beside the valid bits
	always_ff @(posedge clock_i)
	begin
		exOpcodeA_o <= decOpcodeA_i;
		exDestA_o <= decDestA_i;
		opFormatA <= decFormatA_i;
		opOperandA <= decOperandA_i;
		exOpcodeB_o <= decOpcodeB_i;
		exDestB_o <= decDestB_i;
		opFormatB <= decFormatB_i;
		opOperandB <= decOperandB_i;
	end

	// read after the stage register so the previous bundle's
	// writeback is caught by the bypass while it sits on the wb ports
	always_comb
	begin
		// primary always comes from the destination register
		exPrimaryA_o = readBypass(exDestA_o);
		exPrimaryB_o = readBypass(exDestB_o);
		// secondary is the immediate in reg-imm form
		exSecondaryA_o = opFormatA ? opOperandA.immView : readBypass(opOperandA.regView.index);
		exSecondaryB_o = opFormatB ? opOperandB.immView : readBypass(opOperandB.regView.index);
	end

endmodule

`default_nettype wire

/* arithmeticLanes.sv */
`timescale 1ns/1ps
`default_nettype none

module arithmeticLanes
(
	input wire clock_i,
	input wire reset_i,

	// lane a operands
	input wire exValidA_i,
	input wire [vliwPkg::OPCODE_WIDTH-1:0] exOpcodeA_i,
	input wire [vliwPkg::REG_ADDR_WIDTH-1:0] exDestA_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] exPrimaryA_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] exSecondaryA_i,

	// lane b operands
	input wire exValidB_i,
	input wire [vliwPkg::OPCODE_WIDTH-1:0] exOpcodeB_i,
	input wire [vliwPkg::REG_ADDR_WIDTH-1:0] exDestB_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] exPrimaryB_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] exSecondaryB_i,

	// registered writeback
	output logic wbEnableA_o,
	output logic [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrA_o,
	output logic [vliwPkg::DATA_WIDTH-1:0] wbDataA_o,
	output logic wbEnableB_o,
	output logic [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrB_o,
	output logic [vliwPkg::DATA_WIDTH-1:0] wbDataB_o
);

	logic [vliwPkg::DATA_WIDTH-1:0] resultA;
	logic [vliwPkg::DATA_WIDTH-1:0] resultB;

	// one alu body shared by both lanes
	function automatic logic [vliwPkg::DATA_WIDTH-1:0] laneAlu(
		input logic [vliwPkg::OPCODE_WIDTH-1:0] opcode,
		input logic [vliwPkg::DATA_WIDTH-1:0] primary,
		input logic [vliwPkg::DATA_WIDTH-1:0] secondary);
		logic [vliwPkg::SHIFT_WIDTH-1:0] shiftAmount;
		shiftAmount = secondary[vliwPkg::SHIFT_WIDTH-1:0];
		case (opcode)
			vliwPkg::OP_ADD: return primary + secondary;
			vliwPkg::OP_SUB: return primary - secondary;
			vliwPkg::OP_AND: return primary & secondary;
			vliwPkg::OP_OR: return primary | secondary;
			vliwPkg::OP_XOR: return primary ^ secondary;
			// logical shifts, zero fill
			vliwPkg::OP_SHL: return primary << shiftAmount;
			vliwPkg::OP_SHR: return primary >> shiftAmount;
			// move ignores the primary
			vliwPkg::OP_MOV: return secondary;
			// never valid past the decoder
			default: return '0;
		endcase
	endfunction

	always_comb
	begin
		resultA = laneAlu(exOpcodeA_i, exPrimaryA_i, exSecondaryA_i);
		resultB = laneAlu(exOpcodeB_i, exPrimaryB_i, exSecondaryB_i);
	end

	////////////////////////////////////////
	// result registers
	////////////////////////////////////////

	// every valid slot writes back, validity was settled at decode
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			wbEnableA_o <= 1'b0;
			wbEnableB_o <= 1'b0;
		end
		else
		begin
			wbEnableA_o <= exValidA_i;
			wbEnableB_o <= exValidB_i;
		end
	end

	// address and data only matter with the enable
	always_ff @(posedge clock_i)
	begin
		wbAddrA_o <= exDestA_i;
		wbDataA_o <= resultA;
		wbAddrB_o <= exDestB_i;
		wbDataB_o <= resultB;
	end

endmodule

`default_nettype wire

/* vliwCore.sv */
`timescale 1ns/1ps
`default_nettype none

module vliwCore
(
	input wire clock_i,
	input wire reset_i,
	input wire bundleValid_i,
	input wire [vliwPkg::BUNDLE_WIDTH-1:0] bundle_i,

	// writeback, three cycles after the bundle
	output wire wbEnableA_o,
	output wire [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrA_o,
	output wire [vliwPkg::DATA_WIDTH-1:0] wbDataA_o,
	output wire wbEnableB_o,
	output wire [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrB_o,
	output wire [vliwPkg::DATA_WIDTH-1:0] wbDataB_o
);

	////////////////////////////////////////
	// decode to register file
	////////////////////////////////////////

	wire decValidA;
	wire [vliwPkg::OPCODE_WIDTH-1:0] decOpcodeA;
	wire [vliwPkg::REG_ADDR_WIDTH-1:0] decDestA;
	wire decFormatA;
	wire vliwPkg::slotOperand_u decOperandA;
	wire decValidB;
	wire [vliwPkg::OPCODE_WIDTH-1:0] decOpcodeB;
	wire [vliwPkg::REG_ADDR_WIDTH-1:0] decDestB;
	wire decFormatB;
	wire vliwPkg::slotOperand_u decOperandB;

	////////////////////////////////////////
	// register file to lanes
	////////////////////////////////////////

	wire exValidA;
	wire [vliwPkg::OPCODE_WIDTH-1:0] exOpcodeA;
	wire [vliwPkg::REG_ADDR_WIDTH-1:0] exDestA;
	wire [vliwPkg::DATA_WIDTH-1:0] exPrimaryA;
	wire [vliwPkg::DATA_WIDTH-1:0] exSecondaryA;
	wire exValidB;
	wire [vliwPkg::OPCODE_WIDTH-1:0] exOpcodeB;
	wire [vliwPkg::REG_ADDR_WIDTH-1:0] exDestB;
	wire [vliwPkg::DATA_WIDTH-1:0] exPrimaryB;
	wire [vliwPkg::DATA_WIDTH-1:0] exSecondaryB;

	// first stage
	bundleDecoder u_decoder (
		.clock_i(clock_i), .reset_i(reset_i),
		.bundleValid_i(bundleValid_i), .bundle_i(bundle_i),
		.decValidA_o(decValidA), .decOpcodeA_o(decOpcodeA), .decDestA_o(decDestA),
		.decFormatA_o(decFormatA), .decOperandA_o(decOperandA),
		.decValidB_o(decValidB), .decOpcodeB_o(decOpcodeB), .decDestB_o(decDestB),
		.decFormatB_o(decFormatB), .decOperandB_o(decOperandB)
	);

	// second stage, also takes the writeback loop
	registerFile u_registerFile (
		.clock_i(clock_i), .reset_i(reset_i),
		.decValidA_i(decValidA), .decOpcodeA_i(decOpcodeA), .decDestA_i(decDestA),
		.decFormatA_i(decFormatA), .decOperandA_i(decOperandA),
		.decValidB_i(decValidB), .decOpcodeB_i(decOpcodeB), .decDestB_i(decDestB),
		.decFormatB_i(decFormatB), .decOperandB_i(decOperandB),
		.wbEnableA_i(wbEnableA_o), .wbAddrA_i(wbAddrA_o), .wbDataA_i(wbDataA_o),
		.wbEnableB_i(wbEnableB_o), .wbAddrB_i(wbAddrB_o), .wbDataB_i(wbDataB_o),
		.exValidA_o(exValidA), .exOpcodeA_o(exOpcodeA), .exDestA_o(exDestA),
		.exPrimaryA_o(exPrimaryA), .exSecondaryA_o(exSecondaryA),
		.exValidB_o(exValidB), .exOpcodeB_o(exOpcodeB), .exDestB_o(exDestB),
		.exPrimaryB_o(exPrimaryB), .exSecondaryB_o(exSecondaryB)
	);

	// third stage drives the core outputs directly
	arithmeticLanes u_lanes (
		.clock_i(clock_i), .reset_i(reset_i),
		.exValidA_i(exValidA), .exOpcodeA_i(exOpcodeA), .exDestA_i(exDestA),
		.exPrimaryA_i(exPrimaryA), .exSecondaryA_i(exSecondaryA),
		.exValidB_i(exValidB), .exOpcodeB_i(exOpcodeB), .exDestB_i(exDestB),
		.exPrimaryB_i(exPrimaryB), .exSecondaryB_i(exSecondaryB),
		.wbEnableA_o(wbEnableA_o), .wbAddrA_o(wbAddrA_o), .wbDataA_o(wbDataA_o),
		.wbEnableB_o(wbEnableB_o), .wbAddrB_o(wbAddrB_o), .wbDataB_o(wbDataB_o)
	);

endmodule

`default_nettype wire

/* vliwCore_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module vliwCore_asserts
(
	input wire clock_i,
	input wire reset_i,
	input wire bundleValid_i,
	input wire wbEnableA_i,
	input wire wbEnableB_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] wbDataA_i,
	input wire [vliwPkg::DATA_WIDTH-1:0] wbDataB_i
);

	// quiet through reset and the first cycle after it
	resetQuiet: assert property (@(posedge clock_i)
		($past(reset_i) || $past(reset_i, 2)) |-> (!wbEnableA_i && !wbEnableB_i))
		else $error("writeback enable high during or right after reset");

	////////////////////////////////////////
	// latency
	////////////////////////////////////////

	// decoder, operand stage and lane register sit between strobe and writeback
	latencyA: assert property (@(posedge clock_i) disable iff (reset_i)
		wbEnableA_i |-> $past(bundleValid_i, 3))
		else $error("lane a writeback without a bundle three cycles earlier");

	latencyB: assert property (@(posedge clock_i) disable iff (reset_i)
		wbEnableB_i |-> $past(bundleValid_i, 3))
		else $error("lane b writeback without a bundle three cycles earlier");

	// both lanes writing at once
	knownData: assert property (@(posedge clock_i) disable iff (reset_i)
		(wbEnableA_i && wbEnableB_i) |-> !$isunknown({wbDataA_i, wbDataB_i}))
		else $error("writeback data has unknown bits");

endmodule

bind vliwCore vliwCore_asserts u_asserts (
	.clock_i(clock_i),
	.reset_i(reset_i),
	.bundleValid_i(bundleValid_i),
	.wbEnableA_i(wbEnableA_o),
	.wbEnableB_i(wbEnableB_o),
	.wbDataA_i(wbDataA_o),
	.wbDataB_i(wbDataB_o)
);

`default_nettype wire

/* vliwCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module vliwCoreTb;

	////////////////////////////////////////
	// run length and timing
	////////////////////////////////////////

	localparam int CLOCK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 4;
	// from the cycle a bundle is driven to the cycle its writeback is seen
	localparam int LATENCY = 3;
	// idle 4, first add 1, reg-imm 9, reg-reg 8, bypass 3, dropped slots 6
	localparam int DIRECTED_CYCLES = 31;
	localparam int RANDOM_CYCLES = 400;
	localparam int TOTAL_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + LATENCY;
	localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 20) * CLOCK_PERIOD;
	localparam logic [31:0] SEED = 32'hc8af_941c;

	logic clock;
	logic reset;
	logic bundleValid;
	logic [vliwPkg::BUNDLE_WIDTH-1:0] bundle;
	logic wbEnableA;
	logic [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrA;
	logic [vliwPkg::DATA_WIDTH-1:0] wbDataA;
	logic wbEnableB;
	logic [vliwPkg::REG_ADDR_WIDTH-1:0] wbAddrB;
	logic [vliwPkg::DATA_WIDTH-1:0] wbDataB;

	logic [31:0] lcgState;
	// reference register state after every bundle driven so far
	logic [vliwPkg::DATA_WIDTH-1:0] modelRegs [vliwPkg::REG_COUNT];
	// expected writebacks with one entry per driven cycle
	logic expEnableA [$];
	logic [vliwPkg::REG_ADDR_WIDTH-1:0] expAddrA [$];
	logic [vliwPkg::DATA_WIDTH-1:0] expDataA [$];
	logic expEnableB [$];
	logic [vliwPkg::REG_ADDR_WIDTH-1:0] expAddrB [$];
	logic [vliwPkg::DATA_WIDTH-1:0] expDataB [$];

	vliwCore u_dut (
		.clock_i(clock),
		.reset_i(reset),
		.bundleValid_i(bundleValid),
		.bundle_i(bundle),
		.wbEnableA_o(wbEnableA),
		.wbAddrA_o(wbAddrA),
		.wbDataA_o(wbDataA),
		.wbEnableB_o(wbEnableB),
		.wbAddrB_o(wbAddrB),
		.wbDataB_o(wbDataB)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////
	// random numbers
	////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// low lcg bits repeat quickly so the upper half is used
	function automatic int unsigned randomBelow(input int unsigned limit);
		logic [31:0] value;
		value = nextRandom();
		return (value >> 16) % limit;
	endfunction

	// branch, format, opcode, register field, operand from msb down
	function automatic logic [vliwPkg::SLOT_WIDTH-1:0] makeSlot(
		input logic branch,
		input logic format,
		input logic [vliwPkg::OPCODE_WIDTH-1:0] opcode,
		input logic [vliwPkg::REG_ADDR_WIDTH-1:0] dest,
		input logic [vliwPkg::DATA_WIDTH-1:0] operand);
		return {branch, format, opcode, dest, operand};
	endfunction

	// registers kept to 0..7 so slots often collide
	function automatic logic [vliwPkg::SLOT_WIDTH-1:0] randomSlot();
		logic branch;
		logic format;
		logic [vliwPkg::OPCODE_WIDTH-1:0] opcode;
		logic [vliwPkg::REG_ADDR_WIDTH-1:0] dest;
		logic [vliwPkg::DATA_WIDTH-1:0] operand;
		branch = (randomBelow(8) == 0);
		format = (randomBelow(2) == 1);
		// 0 and 9..15 are invalid
		opcode = 7'(randomBelow(16));
		dest = 5'(randomBelow(8));
		if (format)
			operand = 16'(randomBelow(65536));
		else
			operand = {11'(randomBelow(2048)), 5'(randomBelow(8))};
		return makeSlot(branch, format, opcode, dest, operand);
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic logic [vliwPkg::DATA_WIDTH-1:0] expectedResult(
		input logic [vliwPkg::OPCODE_WIDTH-1:0] opcode,
		input logic [vliwPkg::DATA_WIDTH-1:0] primary,
		input logic [vliwPkg::DATA_WIDTH-1:0] secondary);
		logic [vliwPkg::DATA_WIDTH-1:0] result;
		case (opcode)
			vliwPkg::OP_ADD: result = primary + secondary;
			vliwPkg::OP_SUB: result = primary - secondary;
			vliwPkg::OP_AND: result = primary & secondary;
			vliwPkg::OP_OR: result = primary | secondary;
			vliwPkg::OP_XOR: result = primary ^ secondary;
			// shift amount is the low nibble
			vliwPkg::OP_SHL: result = primary << secondary[3:0];
			vliwPkg::OP_SHR: result = primary >> secondary[3:0];
			vliwPkg::OP_MOV: result = secondary;
			default: result = '0;
		endcase
		return result;
	endfunction

	// reads the state from before the bundle and writes nothing
	task automatic modelSlot(
		input logic [vliwPkg::SLOT_WIDTH-1:0] slot,
		output logic enable,
		output logic [vliwPkg::REG_ADDR_WIDTH-1:0] addr,
		output logic [vliwPkg::DATA_WIDTH-1:0] data);
		logic [vliwPkg::OPCODE_WIDTH-1:0] opcode;
		logic [vliwPkg::DATA_WIDTH-1:0] operand;
		logic [vliwPkg::DATA_WIDTH-1:0] secondary;
		opcode = slot[vliwPkg::SLOT_OPCODE_LSB +: vliwPkg::OPCODE_WIDTH];
		operand = slot[vliwPkg::DATA_WIDTH-1:0];
		addr = slot[vliwPkg::SLOT_REG_LSB +: vliwPkg::REG_ADDR_WIDTH];
		enable = !slot[vliwPkg::SLOT_BRANCH_BIT]
			&& (opcode >= vliwPkg::OP_ADD) && (opcode <= vliwPkg::OP_MOV);
		// reg-reg form takes the index from the low operand bits
		if (slot[vliwPkg::SLOT_FORMAT_BIT])
			secondary = operand;
		else
			secondary = modelRegs[operand[vliwPkg::REG_ADDR_WIDTH-1:0]];
		data = expectedResult(opcode, modelRegs[addr], secondary);
	endtask

	task automatic pushExpected(
		input logic enableA,
		input logic [vliwPkg::REG_ADDR_WIDTH-1:0] addrA,
		input logic [vliwPkg::DATA_WIDTH-1:0] dataA,
		input logic enableB,
		input logic [vliwPkg::REG_ADDR_WIDTH-1:0] addrB,
		input logic [vliwPkg::DATA_WIDTH-1:0] dataB);
		expEnableA.push_back(enableA);
		expAddrA.push_back(addrA);
		expDataA.push_back(dataA);
		expEnableB.push_back(enableB);
		expAddrB.push_back(addrB);
		expDataB.push_back(dataB);
	endtask

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	task automatic checkValue(
		input string name,
		input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED time=%0t signal=%s actual=%h expected=%h",
				$time, name, actual, expected);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// address and data are only defined with the enable
	task automatic compareWriteback();
		logic enableA;
		logic enableB;
		logic [vliwPkg::REG_ADDR_WIDTH-1:0] addrA;
		logic [vliwPkg::REG_ADDR_WIDTH-1:0] addrB;
		logic [vliwPkg::DATA_WIDTH-1:0] dataA;
		logic [vliwPkg::DATA_WIDTH-1:0] dataB;
		enableA = expEnableA.pop_front();
		addrA = expAddrA.pop_front();
		dataA = expDataA.pop_front();
		enableB = expEnableB.pop_front();
		addrB = expAddrB.pop_front();
		dataB = expDataB.pop_front();
		checkValue("wbEnableA_o", 16'(wbEnableA), 16'(enableA));
		checkValue("wbEnableB_o", 16'(wbEnableB), 16'(enableB));
		if (enableA)
		begin
			checkValue("wbAddrA_o", 16'(wbAddrA), 16'(addrA));
			checkValue("wbDataA_o", wbDataA, dataA);
		end
		if (enableB)
		begin
			checkValue("wbAddrB_o", 16'(wbAddrB), 16'(addrB));
			checkValue("wbDataB_o", wbDataB, dataB);
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// one clock of checking the due entry, driving the next bundle and predicting it
	task automatic stepCycle(input logic valid, input logic [vliwPkg::BUNDLE_WIDTH-1:0] word);
		logic enableA;
		logic enableB;
		logic [vliwPkg::REG_ADDR_WIDTH-1:0] addrA;
		logic [vliwPkg::REG_ADDR_WIDTH-1:0] addrB;
		logic [vliwPkg::DATA_WIDTH-1:0] dataA;
		logic [vliwPkg::DATA_WIDTH-1:0] dataB;
		@(posedge clock);
		#DRIVE_DELAY;
		compareWriteback();
		bundleValid = valid;
		bundle = word;
		enableA = 1'b0;
		enableB = 1'b0;
		addrA = '0;
		addrB = '0;
		dataA = '0;
		dataB = '0;
		if (valid)
		begin
			modelSlot(word[vliwPkg::BUNDLE_WIDTH-1 -: vliwPkg::SLOT_WIDTH], enableA, addrA, dataA);
			modelSlot(word[vliwPkg::SLOT_WIDTH-1:0], enableB, addrB, dataB);
			// lane b lands second on a shared destination
			if (enableA)
				modelRegs[addrA] = dataA;
			if (enableB)
				modelRegs[addrB] = dataB;
		end
		pushExpected(enableA, addrA, dataA, enableB, addrB, dataB);
	endtask

	task automatic sendPair(
		input logic [vliwPkg::SLOT_WIDTH-1:0] slotA,
		input logic [vliwPkg::SLOT_WIDTH-1:0] slotB);
		stepCycle(1'b1, {slotA, slotB});
	endtask

	// every opcode against an immediate
	task automatic sweepImmediateOps();
		sendPair(makeSlot(1'b0, 1'b1, vliwPkg::OP_MOV, 5'd1, 16'h5a3c),
			makeSlot(1'b0, 1'b1, vliwPkg::OP_MOV, 5'd2, 16'h0f81));
		for (logic [6:0] opcode = vliwPkg::OP_ADD; opcode <= vliwPkg::OP_MOV; opcode++)
			sendPair(makeSlot(1'b0, 1'b1, opcode, 5'd1, 16'(randomBelow(65536))),
				makeSlot(1'b0, 1'b1, opcode, 5'd2, 16'(randomBelow(65536))));
	endtask

	// register view of the operand with junk in the spare bits
	task automatic readRegisterView();
		for (logic [6:0] opcode = vliwPkg::OP_ADD; opcode <= vliwPkg::OP_MOV; opcode++)
			sendPair(makeSlot(1'b0, 1'b0, opcode, 5'd4, {11'(randomBelow(2048)), 5'd1}),
				makeSlot(1'b0, 1'b0, opcode, 5'd5, {11'(randomBelow(2048)), 5'd2}));
	endtask

	// each bundle reads what the one before it wrote
	task automatic chainBypass();
		sendPair(makeSlot(1'b0, 1'b1, vliwPkg::OP_MOV, 5'd10, 16'h1234),
			makeSlot(1'b0, 1'b1, vliwPkg::OP_MOV, 5'd11, 16'h00f0));
		sendPair(makeSlot(1'b0, 1'b0, vliwPkg::OP_OR, 5'd10, 16'd11),
			makeSlot(1'b0, 1'b0, vliwPkg::OP_SUB, 5'd12, 16'd10));
		sendPair(makeSlot(1'b0, 1'b0, vliwPkg::OP_ADD, 5'd11, 16'd12),
			makeSlot(1'b0, 1'b1, vliwPkg::OP_SHL, 5'd10, 16'd3));
	endtask

	task automatic dropSlots();
		// invalid opcodes on both lanes
		sendPair(makeSlot(1'b0, 1'b1, 7'd0, 5'd6, 16'hffff),
			makeSlot(1'b0, 1'b1, 7'd9, 5'd6, 16'hffff));
		sendPair(makeSlot(1'b0, 1'b0, 7'd15, 5'd6, 16'd1),
			makeSlot(1'b0, 1'b1, 7'd127, 5'd6, 16'h00aa));
		// branch flag empties an otherwise good slot
		sendPair(makeSlot(1'b1, 1'b1, vliwPkg::OP_ADD, 5'd6, 16'h0101),
			makeSlot(1'b1, 1'b1, vliwPkg::OP_MOV, 5'd6, 16'h0202));
		sendPair(makeSlot(1'b1, 1'b1, vliwPkg::OP_MOV, 5'd13, 16'h0303),
			makeSlot(1'b0, 1'b1, vliwPkg::OP_MOV, 5'd13, 16'h7777));
		// lane b wins on a shared destination
		sendPair(makeSlot(1'b0, 1'b1, vliwPkg::OP_MOV, 5'd14, 16'h1111),
			makeSlot(1'b0, 1'b1, vliwPkg::OP_MOV, 5'd14, 16'h2222));
		sendPair(makeSlot(1'b0, 1'b0, vliwPkg::OP_MOV, 5'd15, 16'd14),
			makeSlot(1'b0, 1'b1, vliwPkg::OP_ADD, 5'd14, 16'd1));
	endtask

	// strobe low about one cycle in four while slot bits still toggle
	task automatic streamRandomBundles();
		logic valid;
		logic [vliwPkg::SLOT_WIDTH-1:0] slotA;
		logic [vliwPkg::SLOT_WIDTH-1:0] slotB;
		for (int i = 0; i < RANDOM_CYCLES; i++)
		begin
			valid = (randomBelow(4) != 0);
			slotA = randomSlot();
			slotB = randomSlot();
			stepCycle(valid, {slotA, slotB});
		end
	endtask

	initial
	begin
		lcgState = SEED;
		reset = 1'b1;
		bundleValid = 1'b0;
		bundle = '0;
		for (int i = 0; i < vliwPkg::REG_COUNT; i++)
			modelRegs[i] = '0;
		// pipeline holds nothing when the first checks come due
		repeat (LATENCY) pushExpected(1'b0, '0, '0, 1'b0, '0, '0);
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		repeat (4) stepCycle(1'b0, '0);
		// adding zero to untouched registers gives zero
		sendPair(makeSlot(1'b0, 1'b1, vliwPkg::OP_ADD, 5'd3, 16'h0000),
			makeSlot(1'b0, 1'b1, vliwPkg::OP_ADD, 5'd7, 16'h0000));
		sweepImmediateOps();
		readRegisterView();
		chainBypass();
		dropSlots();
		streamRandomBundles();
		// drain the last bundles
		repeat (LATENCY) stepCycle(1'b0, '0);
		$display("All tests passed!");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("TIMEOUT stimulus did not finish within %0d ns", WATCHDOG_TIME);
		$display("Test failures found");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* all.f */
vliwPkg.sv
bundleDecoder.sv
registerFile.sv
arithmeticLanes.sv
vliwCore.sv
vliwCore_asserts.sv
vliwCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the vliwCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BINARY=vliwCoreSim
LOG_FILE=sim.log
PASS_TEXT='All tests passed!'

verilator --binary --timing --assert -Wno-fatal \
	--top-module vliwCoreTb \
	-f all.f \
	--Mdir "$BUILD_DIR" -o "$SIM_BINARY"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BINARY" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qF "$PASS_TEXT" "$LOG_FILE"; then
	echo "RESULT: PASS"
	exit 0
fi
echo "RESULT: FAIL"
exit 1
